// ==== Makefile ====
# Verilator flow for the banked execution core

VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bank_reg_file.sv ====
/*
 * bank_reg_file: four banks of general registers plus shared pointers,
 * bank-relative code resolution, sized writes, steps and byte dump
 */
`timescale 1ns/10ps

module bank_reg_file import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_code_u   src_code,
    input  reg_code_u   dst_code,
    input  wr_req_t     wr,
    input  logic [7:0]  dmp_addr,
    input  logic [15:0] sr,
    output logic [31:0] src_data,
    output logic [31:0] dst_data,
    output logic        bc_unity,
    output logic [1:0]  rfp,
    output logic [7:0]  dmp_data
);

    // general bytes at bank*16+index, then the 16 pointer bytes
    logic [7:0]                 file_q  [BANK_COUNT*16+16];
    logic [7:0]                 byte_wd [BANK_COUNT*16+16];
    logic [BANK_COUNT*16+15:0]  byte_we;

    reg_code_u   src_res;
    reg_code_u   dst_res;
    reg_code_u   ex_res;
    reg_code_u   bc_code;
    logic [31:0] src_raw;
    logic [31:0] bc_word;
    logic [31:0] step_val;
    logic [31:0] stepped;

    // port 0 is the main write, port 1 the exchange partner
    reg_code_u   port_code [2];
    size_e       port_size [2];
    logic [31:0] port_data [2];
    logic [1:0]  port_en;

    function automatic reg_code_u resolve(input logic [1:0] bank_ptr, input reg_code_u code);
        reg_code_u res;
        res = code;
        if (code.gen.bank == CUR_BANK_CODE) begin
            res.gen.bank = {2'b00, bank_ptr};
        end else if (code.gen.bank == PREV_BANK_CODE) begin
            res.gen.bank = {2'b00, bank_ptr - 2'd1};
        end
        return res;
    endfunction

    // upper lanes sit on the aligned neighbours of the coded byte
    function automatic logic [3:0] lane_idx(input logic [3:0] idx, input logic [1:0] lane);
        case (lane)
            2'd0:    return idx;
            2'd1:    return {idx[3:1], 1'b1};
            2'd2:    return {idx[3:2], 2'b10};
            default: return {idx[3:2], 2'b11};
        endcase
    endfunction

    function automatic logic [6:0] byte_addr(input reg_code_u code, input logic [1:0] lane);
        if (code[PTR_CODE_BIT]) begin
            return 7'(BANK_COUNT * 16) + {3'd0, lane_idx(code.ptr.idx, lane)};
        end
        return {1'b0, code.gen.bank[1:0], lane_idx(code.gen.idx, lane)};
    endfunction

    function automatic logic [31:0] read_reg(input reg_code_u code);
        logic [31:0] val;
        for (int lane = 0; lane < 4; lane++) begin
            val[lane*8 +: 8] = file_q[byte_addr(code, 2'(lane))];
        end
        return val;
    endfunction

    function automatic logic [2:0] size_bytes(input size_e size);
        case (size)
            BYTE:    return 3'd1;
            WORD:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // operand reads
    always_comb begin
        src_res          = resolve(rfp, src_code);
        dst_res          = resolve(rfp, dst_code);
        ex_res           = resolve(rfp, wr.ex_code);
        bc_code.gen.bank = {2'b00, rfp};
        bc_code.gen.idx  = BC_OFFSET;

        src_raw  = read_reg(src_res);
        dst_data = read_reg(dst_res);
        bc_word  = read_reg(bc_code);
        src_data = (src_code.gen.bank == ZERO_CODE_NIBBLE) ? 32'd0 : src_raw;
        bc_unity = (bc_word[15:0] == 16'd1);

        step_val = {29'd0, size_bytes(wr.step_size)};
        stepped  = wr.step_dec ? src_raw - step_val : src_raw + step_val;
    end

    // pick what the two write ports carry this cycle
    always_comb begin
        port_en      = {wr.ex_we, wr.we | wr.step_en | wr.dec_bc};
        port_code[1] = ex_res;
        port_size[1] = wr.size;
        port_data[1] = dst_data;
        if (wr.step_en) begin
            // steps always rewrite the full 32-bit register
            port_code[0] = src_res;
            port_size[0] = LONG;
            port_data[0] = stepped;
        end else if (wr.dec_bc) begin
            port_code[0] = bc_code;
            port_size[0] = WORD;
            port_data[0] = {bc_word[31:16], bc_word[15:0] - 16'd1};
        end else begin
            port_code[0] = resolve(rfp, wr.dst);
            port_size[0] = wr.size;
            port_data[0] = wr.data;
        end
    end

    // spread the ports onto byte enables
    always_comb begin
        byte_we = '0;
        for (int i = 0; i < BANK_COUNT*16+16; i++) begin
            byte_wd[i] = 8'h00;
        end
        // partner goes first so the destination wins on overlap
        for (int p = 1; p >= 0; p--) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (port_en[p] && (3'(lane) < size_bytes(port_size[p]))) begin
                    byte_we[byte_addr(port_code[p], 2'(lane))] = 1'b1;
                    byte_wd[byte_addr(port_code[p], 2'(lane))] = port_data[p][lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BANK_COUNT*16+16; i++) begin
                file_q[i] <= 8'h00;
            end
        end else begin
            for (int i = 0; i < BANK_COUNT*16+16; i++) begin
                if (byte_we[i]) begin
                    file_q[i] <= byte_wd[i];
                end
            end
        end
    end

    // bank pointer wraps mod 4
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else if (wr.rfp_set) begin
            rfp <= wr.rfp_val;
        end else if (wr.rfp_inc) begin
            rfp <= rfp + 2'd1;
        end else if (wr.rfp_dec) begin
            rfp <= rfp - 2'd1;
        end
    end

    // dump: register bytes first, status bytes right after them
    always_ff @(posedge clk) begin
        if (dmp_addr < DUMP_SR_HI) begin
            dmp_data <= file_q[dmp_addr[6:0]];
        end else if (dmp_addr == DUMP_SR_HI) begin
            dmp_data <= sr[15:8];
        end else if (dmp_addr == DUMP_SR_LO) begin
            dmp_data <= sr[7:0];
        end else begin
            dmp_data <= 8'h00;
        end
    end

    // the sequencer issues a single kind of update per cycle
    a_wr_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({wr.we, wr.step_en, wr.dec_bc, wr.rfp_set, wr.rfp_inc, wr.rfp_dec}));

    a_ex_with_we: assert property (@(posedge clk) disable iff (rst)
        wr.ex_we |-> wr.we);

endmodule

// ==== cmd_sequencer.sv ====
/*
 * cmd_sequencer: takes one command at a time, drives the execute
 * step into the register file and ALU, then holds the response
 */
`timescale 1ns/10ps

module cmd_sequencer import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  cmd_t        cmd,
    input  logic        rsp_ready,
    input  logic [31:0] src_data,
    input  logic [31:0] dst_data,
    input  logic [31:0] alu_result,
    input  alu_flags_t  alu_flags,
    input  logic        bc_unity,
    input  logic [1:0]  rfp,
    output logic        cmd_ready,
    output logic        rsp_valid,
    output rsp_t        rsp,
    output reg_code_u   src_code,
    output reg_code_u   dst_code,
    output op_e         alu_op,
    output size_e       alu_size,
    output logic        flag_we,
    output wr_req_t     wr
);

    // exec issues the write, load samples the post-write state
    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_LOAD, S_RESP} state_e;

    state_e    state;
    cmd_t      cmd_q;
    rsp_t      rsp_d;
    logic      is_alu;
    reg_code_u bc_code;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC:  state <= S_LOAD;
                S_LOAD:  state <= S_RESP;
                default: begin
                    if (rsp_ready) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == S_LOAD) begin
            rsp <= rsp_d;
        end
    end

    assign cmd_ready = (state == S_IDLE);
    assign rsp_valid = (state == S_RESP);

    assign is_alu  = cmd_q.op inside {ADD, SUB, AND, XOR};
    assign flag_we = (state == S_EXEC) && is_alu;

    // DEC_BC reads back the current-bank BC pair
    assign bc_code  = {CUR_BANK_CODE, BC_OFFSET};
    assign src_code = cmd_q.src;
    assign dst_code = (cmd_q.op == DEC_BC) ? bc_code : cmd_q.dst;
    assign alu_op   = cmd_q.op;
    assign alu_size = cmd_q.size;

    always_comb begin
        wr           = '0;
        wr.size      = cmd_q.size;
        wr.dst       = cmd_q.dst;
        wr.ex_code   = cmd_q.src;
        wr.step_size = cmd_q.size;
        wr.step_dec  = (cmd_q.op == PTR_DEC);
        wr.rfp_val   = cmd_q.bank;
        if (is_alu) begin
            wr.data = alu_result;
        end else if (cmd_q.op == EXCH) begin
            wr.data = src_data;
        end else begin
            wr.data = cmd_q.imm;
        end
        if (state == S_EXEC) begin
            case (cmd_q.op)
                LOAD_IMM, ADD, SUB, AND, XOR: wr.we = 1'b1;
                EXCH: begin
                    wr.we    = 1'b1;
                    wr.ex_we = 1'b1;
                end
                PTR_INC, PTR_DEC: wr.step_en = 1'b1;
                DEC_BC:           wr.dec_bc  = 1'b1;
                RFP_SET:          wr.rfp_set = 1'b1;
                RFP_INC:          wr.rfp_inc = 1'b1;
                RFP_DEC:          wr.rfp_dec = 1'b1;
                default:          wr.we      = 1'b0;
            endcase
        end
    end

    // response from the state after the write has landed
    always_comb begin
        rsp_d.op       = cmd_q.op;
        rsp_d.flags    = alu_flags;
        rsp_d.bc_unity = bc_unity;
        rsp_d.rfp      = rfp;
        case (cmd_q.op)
            RFP_SET, RFP_INC, RFP_DEC: rsp_d.result = 32'd0;
            PTR_INC, PTR_DEC:          rsp_d.result = src_data;
            DEC_BC:                    rsp_d.result = {16'd0, dst_data[15:0]};
            default:                   rsp_d.result = dst_data;
        endcase
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== exec_alu.sv ====
/*
 * exec_alu: sized add, sub, and, xor with flag generation
 * and the status register kept for the response and the dump
 */
`timescale 1ns/10ps

module exec_alu import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  op_e         op,
    input  size_e       size,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic        flag_we,
    output logic [31:0] result,
    output alu_flags_t  flags,
    output logic [15:0] sr
);

    logic [31:0] mask;
    logic [31:0] raw;
    logic [32:0] sum;
    logic [32:0] diff;
    logic        carry;
    alu_flags_t  next_flags;
    alu_flags_t  flags_q;

    // bit just above the sized field
    function automatic logic size_tap(input logic [32:0] v, input size_e sz);
        case (sz)
            BYTE:    return v[8];
            WORD:    return v[16];
            default: return v[32];
        endcase
    endfunction

    always_comb begin
        case (size)
            BYTE:    mask = 32'h0000_00ff;
            WORD:    mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase

        // operands masked so the carry/borrow shows at the size's tap
        sum  = {1'b0, b & mask} + {1'b0, a & mask};
        diff = {1'b0, b & mask} - {1'b0, a & mask};

        raw   = b;
        carry = 1'b0;
        case (op)
            ADD: begin
                raw   = sum[31:0];
                carry = size_tap(sum, size);
            end
            SUB: begin
                raw   = diff[31:0];
                carry = size_tap(diff, size);
            end
            AND:     raw = b & a;
            XOR:     raw = b ^ a;
            default: raw = b;
        endcase

        // bytes above the size pass through from the destination
        result = (raw & mask) | (b & ~mask);

        // shifted by one, the tap lands on the sized sign bit
        next_flags.s = size_tap({result, 1'b0}, size);
        next_flags.z = ((raw & mask) == 32'd0);
        next_flags.h = 1'b0;
        next_flags.c = carry;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags_q <= '0;
        end else if (flag_we) begin
            flags_q <= next_flags;
        end
    end

    assign flags = flags_q;
    // low byte laid out S Z - H - - - C, high byte filled in at the top
    assign sr = {8'h00, flags_q.s, flags_q.z, 1'b0, flags_q.h, 3'b000, flags_q.c};

endmodule

// ==== exec_core.sv ====
/*
 * exec_core: banked execution datapath, sequencer driving
 * the register file and the ALU
 */
`timescale 1ns/10ps

module exec_core import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_valid,
    input  cmd_t       cmd,
    input  logic       rsp_ready,
    input  logic [7:0] dmp_addr,
    output logic       cmd_ready,
    output logic       rsp_valid,
    output rsp_t       rsp,
    output logic [7:0] dmp_data
);

    reg_code_u   src_code;
    reg_code_u   dst_code;
    logic [31:0] src_data;
    logic [31:0] dst_data;
    logic [31:0] alu_result;
    alu_flags_t  alu_flags;
    logic        bc_unity;
    logic [1:0]  rfp;
    op_e         alu_op;
    size_e       alu_size;
    logic        flag_we;
    wr_req_t     wr;
    logic [15:0] alu_sr;
    logic [15:0] sr;

    // bank pointer sits in bits 9:8 of the status word
    assign sr = alu_sr | {6'd0, rfp, 8'd0};

    cmd_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .rsp_ready  (rsp_ready),
        .src_data   (src_data),
        .dst_data   (dst_data),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .bc_unity   (bc_unity),
        .rfp        (rfp),
        .cmd_ready  (cmd_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .src_code   (src_code),
        .dst_code   (dst_code),
        .alu_op     (alu_op),
        .alu_size   (alu_size),
        .flag_we    (flag_we),
        .wr         (wr)
    );

    bank_reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .src_code (src_code),
        .dst_code (dst_code),
        .wr       (wr),
        .dmp_addr (dmp_addr),
        .sr       (sr),
        .src_data (src_data),
        .dst_data (dst_data),
        .bc_unity (bc_unity),
        .rfp      (rfp),
        .dmp_data (dmp_data)
    );

    exec_alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .op      (alu_op),
        .size    (alu_size),
        .a       (src_data),
        .b       (dst_data),
        .flag_we (flag_we),
        .result  (alu_result),
        .flags   (alu_flags),
        .sr      (alu_sr)
    );

endmodule

// ==== exec_pkg.sv ====
/*
 * exec_pkg: shared constants, register-code union and the command,
 * response and write-request structs of the banked execution core
 */
package exec_pkg;

    // four banks of 16 general bytes, pointer bytes follow them
    localparam int BANK_COUNT = 4;

    // bank-relative code nibbles, resolved through the bank pointer
    localparam logic [3:0] CUR_BANK_CODE  = 4'he;
    localparam logic [3:0] PREV_BANK_CODE = 4'hd;
    localparam int         PTR_CODE_BIT   = 7;
    // as a source this nibble reads as zero
    localparam logic [3:0] ZERO_CODE_NIBBLE = 4'h4;

    // status bytes on the dump port
    localparam logic [7:0] DUMP_SR_HI = 8'h50;
    localparam logic [7:0] DUMP_SR_LO = 8'h51;

    // BC pair inside the current bank
    localparam logic [3:0] BC_OFFSET = 4'd4;

    typedef enum logic [3:0] {
        LOAD_IMM, ADD, SUB, AND, XOR, EXCH, PTR_INC, PTR_DEC,
        DEC_BC, RFP_SET, RFP_INC, RFP_DEC
    } op_e;

    // operand size, also the pointer step of 1, 2 or 4
    typedef enum logic [1:0] {
        BYTE, WORD, LONG
    } size_e;

    typedef struct packed {
        logic [3:0] bank;
        logic [3:0] idx;
    } gen_code_t;

    typedef struct packed {
        logic       flag;
        logic [2:0] pad;
        logic [3:0] idx;
    } ptr_code_t;

    typedef union packed {
        gen_code_t gen;
        ptr_code_t ptr;
    } reg_code_u;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic c;
    } alu_flags_t;

    typedef struct packed {
        op_e         op;
        size_e       size;
        reg_code_u   src;
        reg_code_u   dst;
        logic [31:0] imm;
        logic [1:0]  bank;
    } cmd_t;

    typedef struct packed {
        op_e         op;
        logic [31:0] result;
        alu_flags_t  flags;
        logic        bc_unity;
        logic [1:0]  rfp;
    } rsp_t;

    typedef struct packed {
        logic        we;
        size_e       size;
        reg_code_u   dst;
        logic [31:0] data;
        logic        ex_we;
        reg_code_u   ex_code;
        logic        step_en;
        logic        step_dec;
        size_e       step_size;
        logic        dec_bc;
        logic        rfp_set;
        logic        rfp_inc;
        logic        rfp_dec;
        logic [1:0]  rfp_val;
    } wr_req_t;

endpackage

// ==== sources.f ====
exec_pkg.sv
bank_reg_file.sv
exec_alu.sv
cmd_sequencer.sv
exec_core.sv
tb_exec_core.sv

// ==== tb_exec_core.sv ====
/*
 * tb_exec_core: drives commands into the execution core, predicts
 * every response with a model of the banks, and checks the dump port
 */
`timescale 1ns/10ps

module tb_exec_core import exec_pkg::*; ();

    localparam int ALU_REPS = 4;
    localparam int BP_CMDS  = 30;
    // commands and dump reads per test, each given 10 cycles below
    localparam int N_STEPS  = 9 * 14 + 4 * 3 * ALU_REPS * 5 + 6 * 8 + 40 + 20 + BP_CMDS;
    localparam int WATCH_CYCLES = N_STEPS * 10 + 200;

    logic       clk;
    logic       rst;
    logic       cmd_valid;
    cmd_t       cmd;
    logic       rsp_ready;
    logic [7:0] dmp_addr;
    logic       cmd_ready;
    logic       rsp_valid;
    rsp_t       rsp;
    logic [7:0] dmp_data;

    integer seed = 71130;
    integer rdy_seed = 71130;
    int     cyc;
    int     checks;
    int     errors;
    int     sent;
    int     received;
    int     err_mark;
    logic   bp_mode;

    // model of the register file and status
    logic [7:0] m_file [80];
    logic [1:0] m_rfp;
    alu_flags_t m_flags;

    rsp_t exp_q [$];
    int   acc_q [$];

    exec_core u_dut (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp_ready (rsp_ready),
        .dmp_addr  (dmp_addr),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .dmp_data  (dmp_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
        end
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // physical byte address of a register code
    function automatic int phys(input logic [7:0] code);
        int bank;
        if (code[7:4] == 4'he) begin
            bank = m_rfp;
        end else if (code[7:4] == 4'hd) begin
            bank = (int'(m_rfp) + 3) % 4;
        end else if (code[7]) begin
            return 64 + code[3:0];
        end else begin
            bank = code[5:4];
        end
        return bank * 16 + code[3:0];
    endfunction

    function automatic logic [31:0] get_reg(input logic [7:0] code);
        logic [31:0] v;
        for (int k = 0; k < 4; k++) begin
            v[k*8 +: 8] = m_file[phys(code) + k];
        end
        return v;
    endfunction

    function automatic void put_reg(input logic [7:0] code, input logic [31:0] v, input int nb);
        for (int k = 0; k < nb; k++) begin
            m_file[phys(code) + k] = v[k*8 +: 8];
        end
    endfunction

    // reference model, applies one command and returns the response
    function automatic rsp_t predict(input cmd_t c);
        rsp_t        r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mask;
        logic [31:0] rs;
        logic [31:0] v;
        logic        cy;
        int          nb;
        nb   = (c.size == BYTE) ? 1 : (c.size == WORD) ? 2 : 4;
        mask = (nb == 4) ? 32'hffff_ffff : ((32'd1 << (8 * nb)) - 32'd1);
        a    = (c.src[7:4] == 4'h4) ? 32'd0 : get_reg(c.src);
        b    = get_reg(c.dst);
        rs   = '0;
        cy   = 1'b0;
        case (c.op)
            LOAD_IMM: put_reg(c.dst, c.imm, nb);
            ADD, SUB, AND, XOR: begin
                if (c.op == ADD) begin
                    // a sized sum that wrapped ends below either operand
                    rs = (b + a) & mask;
                    cy = rs < (a & mask);
                end else if (c.op == SUB) begin
                    rs = ((b & mask) - (a & mask)) & mask;
                    cy = (a & mask) > (b & mask);
                end else if (c.op == AND) begin
                    rs = b & a & mask;
                end else begin
                    rs = (b ^ a) & mask;
                end
                m_flags.s = rs[8*nb-1];
                m_flags.z = (rs == 32'd0);
                m_flags.h = 1'b0;
                m_flags.c = cy;
                put_reg(c.dst, (b & ~mask) | rs, 4);
            end
            EXCH: begin
                put_reg(c.src, b, nb);
                put_reg(c.dst, a, nb);
            end
            PTR_INC: put_reg(c.src, get_reg(c.src) + 32'(nb), 4);
            PTR_DEC: put_reg(c.src, get_reg(c.src) - 32'(nb), 4);
            DEC_BC: begin
                v = get_reg(8'he4);
                put_reg(8'he4, {16'd0, v[15:0] - 16'd1}, 2);
            end
            RFP_SET: m_rfp = c.bank;
            RFP_INC: m_rfp = m_rfp + 2'd1;
            RFP_DEC: m_rfp = m_rfp - 2'd1;
            default: ;
        endcase
        v = get_reg(8'he4);
        case (c.op)
            RFP_SET, RFP_INC, RFP_DEC: r.result = 32'd0;
            PTR_INC, PTR_DEC:          r.result = get_reg(c.src);
            DEC_BC:                    r.result = {16'd0, v[15:0]};
            default:                   r.result = get_reg(c.dst);
        endcase
        r.op       = c.op;
        r.flags    = m_flags;
        r.bc_unity = (v[15:0] == 16'd1);
        r.rfp      = m_rfp;
        return r;
    endfunction

    function automatic cmd_t make_cmd(input op_e op, input size_e sz, input logic [7:0] src,
                                      input logic [7:0] dst, input logic [31:0] imm,
                                      input logic [1:0] bank);
        cmd_t c;
        c.op   = op;
        c.size = sz;
        c.src  = src;
        c.dst  = dst;
        c.imm  = imm;
        c.bank = bank;
        return c;
    endfunction

    task automatic send(input cmd_t c);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        // accepted on the coming edge
        acc_q.push_back(cyc + 1);
        exp_q.push_back(predict(c));
        sent++;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || !cmd_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic dump_byte(input logic [7:0] addr, output logic [7:0] val);
        @(posedge clk);
        dmp_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        val = dmp_data;
    endtask

    task automatic dump_reg(input logic [7:0] code);
        logic [7:0] got;
        int         base;
        wait_idle();
        base = phys(code);
        for (int k = 0; k < 4; k++) begin
            dump_byte(8'(base + k), got);
            check(got, m_file[base + k], $sformatf("dump byte %0d", base + k));
        end
    endtask

    task automatic dump_status();
        logic [7:0] got;
        wait_idle();
        dump_byte(DUMP_SR_HI, got);
        check(got, {6'd0, m_rfp}, "status high byte");
        dump_byte(DUMP_SR_LO, got);
        check(got, {m_flags.s, m_flags.z, 1'b0, m_flags.h, 3'b000, m_flags.c},
              "status low byte");
    endtask

    task automatic test_end(input string name);
        wait_idle();
        $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // compares each accepted response and watches the handshake
    initial begin : compare_rsp
        rsp_t held;
        rsp_t e;
        logic hold;
        logic prev_valid;
        hold       = 1'b0;
        prev_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (hold) begin
                    check(rsp_valid, 1'b1, "rsp_valid under back-pressure");
                    check(rsp, held, "rsp under back-pressure");
                end
                if (rsp_valid) begin
                    check(cmd_ready, 1'b0, "cmd_ready while response held");
                end
                if (rsp_valid && !prev_valid) begin
                    if (acc_q.size() == 0) begin
                        errors++;
                        $display("Error at %0t: response raised with no accepted command", $time);
                    end else begin
                        check(cyc - acc_q.pop_front(), 2, "response latency");
                    end
                end
                if (rsp_valid && rsp_ready) begin
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("Error at %0t: response taken with no command pending", $time);
                    end else begin
                        e = exp_q.pop_front();
                        check(rsp.op, e.op, "rsp op");
                        check(rsp.result, e.result, $sformatf("rsp result of %s", e.op.name()));
                        check(rsp.flags, e.flags, $sformatf("rsp flags of %s", e.op.name()));
                        check(rsp.bc_unity, e.bc_unity, "rsp bc_unity");
                        check(rsp.rfp, e.rfp, "rsp rfp");
                    end
                    received++;
                end
                hold       = rsp_valid && !rsp_ready;
                held       = rsp;
                prev_valid = rsp_valid;
            end
        end
    end

    // random stretches of rsp_ready low while back-pressure is on
    initial begin : ready_drive
        int stretch;
        stretch = 0;
        forever begin
            @(posedge clk);
            if (!bp_mode) begin
                rsp_ready <= 1'b1;
            end else if (stretch > 0) begin
                stretch--;
                rsp_ready <= 1'b0;
            end else if ($random(rdy_seed) & 1) begin
                stretch = 1 + ($unsigned($random(rdy_seed)) % 4);
                rsp_ready <= 1'b0;
            end else begin
                rsp_ready <= 1'b1;
            end
        end
    end

    initial begin
        #(WATCH_CYCLES * 20);
        $display("timeout: the run did not finish within %0d cycles", WATCH_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [7:0] codes [8];
        op_e        ops [10];
        logic [7:0] tgt [3];
        int         n;
        codes = '{8'h00, 8'h14, 8'h28, 8'h3c, 8'he8, 8'hdc, 8'h84, 8'h8c};
        ops   = '{LOAD_IMM, ADD, SUB, AND, XOR, PTR_INC, PTR_DEC, DEC_BC, RFP_INC, RFP_DEC};
        tgt   = '{8'h08, 8'h84, 8'h3c};
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rsp_ready = 1'b1;
        dmp_addr  = 8'h00;
        bp_mode   = 1'b0;
        checks    = 0;
        errors    = 0;
        sent      = 0;
        received  = 0;
        err_mark  = 0;
        m_rfp     = 2'd0;
        m_flags   = '0;
        for (int i = 0; i < 80; i++) begin
            m_file[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // sized loads, upper bytes kept
        for (int t = 0; t < 3; t++) begin
            for (int s = 0; s < 3; s++) begin
                send(make_cmd(LOAD_IMM, LONG, 8'h00, tgt[t], $random(seed), 2'd0));
                send(make_cmd(LOAD_IMM, size_e'(s), 8'h00, tgt[t], $random(seed), 2'd0));
                dump_reg(tgt[t]);
            end
        end
        test_end("load_imm");

        // byte add wrapping to zero with carry
        send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h10, 32'h1234_56ff, 2'd0));
        send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h24, 32'h0000_0001, 2'd0));
        send(make_cmd(ADD, BYTE, 8'h24, 8'h10, 32'd0, 2'd0));
        dump_status();
        for (int o = 0; o < 4; o++) begin
            for (int s = 0; s < 3; s++) begin
                for (int r = 0; r < ALU_REPS; r++) begin
                    send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h10, $random(seed), 2'd0));
                    send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h24, $random(seed), 2'd0));
                    send(make_cmd(op_e'(1 + o), size_e'(s), 8'h24, 8'h10, 32'd0, 2'd0));
                    dump_status();
                end
            end
        end
        test_end("alu");

        send(make_cmd(RFP_SET, LONG, 8'h00, 8'h00, 32'd0, 2'd2));
        for (int i = 0; i < 6; i++) begin
            send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'he0, $random(seed), 2'd0));
            send(make_cmd(LOAD_IMM, WORD, 8'h00, 8'hd8, $random(seed), 2'd0));
            dump_reg(8'he0);
            dump_reg(8'hd8);
            send(make_cmd((i < 3) ? RFP_INC : RFP_DEC, LONG, 8'h00, 8'h00, 32'd0, 2'd0));
            dump_status();
        end
        // zero-nibble source leaves the destination as it was
        send(make_cmd(ADD, LONG, 8'h40, 8'he0, 32'd0, 2'd0));
        send(make_cmd(XOR, WORD, 8'h48, 8'hd8, 32'd0, 2'd0));
        test_end("bank_pointer");

        send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h80, $random(seed), 2'd0));
        send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h30, $random(seed), 2'd0));
        for (int s = 2; s >= 0; s--) begin
            send(make_cmd(EXCH, size_e'(s), 8'h80, 8'h30, 32'd0, 2'd0));
            dump_reg(8'h80);
            dump_reg(8'h30);
        end
        send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h88, 32'hffff_fffe, 2'd0));
        for (int s = 0; s < 3; s++) begin
            send(make_cmd(PTR_INC, size_e'(s), 8'h88, 8'h00, 32'd0, 2'd0));
        end
        for (int s = 0; s < 3; s++) begin
            send(make_cmd(PTR_DEC, size_e'(s), 8'h88, 8'h00, 32'd0, 2'd0));
        end
        send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'h8c, 32'h0000_0001, 2'd0));
        send(make_cmd(PTR_DEC, LONG, 8'h8c, 8'h00, 32'd0, 2'd0));
        dump_reg(8'h88);
        dump_reg(8'h8c);
        test_end("exchange_pointer");

        send(make_cmd(RFP_SET, LONG, 8'h00, 8'h00, 32'd0, 2'd1));
        send(make_cmd(LOAD_IMM, LONG, 8'h00, 8'he4, 32'habcd_0003, 2'd0));
        repeat (5) send(make_cmd(DEC_BC, WORD, 8'h00, 8'h00, 32'd0, 2'd0));
        dump_reg(8'he4);
        send(make_cmd(LOAD_IMM, WORD, 8'h00, 8'he4, 32'h0000_0002, 2'd0));
        send(make_cmd(DEC_BC, WORD, 8'h00, 8'h00, 32'd0, 2'd0));
        test_end("dec_bc");

        bp_mode = 1'b1;
        for (int i = 0; i < BP_CMDS; i++) begin
            n = $unsigned($random(seed)) % 10;
            send(make_cmd(ops[n], size_e'($unsigned($random(seed)) % 3),
                          codes[$unsigned($random(seed)) % 8],
                          codes[$unsigned($random(seed)) % 8], $random(seed), 2'd0));
        end
        wait_idle();
        bp_mode = 1'b0;
        test_end("back_pressure");

        if (sent != received) begin
            errors++;
            $display("Error: %0d commands sent but %0d responses received", sent, received);
        end
        $display("checks %0d, errors %0d, commands %0d", checks, errors, sent);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
